// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int data_w   = 64;
    localparam int regnum_w = 5;
    localparam int imm_w    = 16;
    localparam int shamt_w  = 5;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR} alu_op_t;
    typedef enum logic [1:0] {SRC2_REG, SRC2_SEXT_IMM, SRC2_ZEXT_IMM} alu_src2_t;
    typedef enum logic [1:0] {SLT_NONE, SLT_SIGNED, SLT_UNSIGNED} slt_type_t;
    typedef enum logic [1:0] {CUT_NONE, CUT_SEXT, CUT_ZEXT} cut32_t;
    typedef enum logic [1:0] {PLUS32_NONE, PLUS32_LEFT, PLUS32_RIGHT} plus32_t;
    typedef enum logic [1:0] {FWD_REG, FWD_EX, FWD_WB} forward_type_t;

    // ######################################################################
    // stage structs
    // ######################################################################

    typedef struct packed {
        logic                valid;
        logic [regnum_w-1:0] src_a;
        logic [regnum_w-1:0] src_b;
        logic [regnum_w-1:0] dest;
        logic [imm_w-1:0]    imm;
        logic [shamt_w-1:0]  shamt;
        alu_op_t             alu_op;
        alu_src2_t           alu_src2;
        slt_type_t           slt_type;
        cut32_t              cut_alu_out32;
        logic                alu_shifter_src;   // 1 selects the shifter path.
        logic                shift_right;
        logic                shift_arith;
        cut32_t              cut_shifter_out32;
        plus32_t             shifter_plus32;
        logic                lui;
        logic                write_enable;
        logic                ignore_overflow;
    } issue_op_t;

    // same field order as issue_op_t, operands appended at the bottom.
    typedef struct packed {
        logic                valid;
        logic [regnum_w-1:0] src_a;
        logic [regnum_w-1:0] src_b;
        logic [regnum_w-1:0] dest;
        logic [imm_w-1:0]    imm;
        logic [shamt_w-1:0]  shamt;
        alu_op_t             alu_op;
        alu_src2_t           alu_src2;
        slt_type_t           slt_type;
        cut32_t              cut_alu_out32;
        logic                alu_shifter_src;
        logic                shift_right;
        logic                shift_arith;
        cut32_t              cut_shifter_out32;
        plus32_t             shifter_plus32;
        logic                lui;
        logic                write_enable;
        logic                ignore_overflow;
        logic [data_w-1:0]   a_data;
        logic [data_w-1:0]   b_data;
    } id_regs_t;

    typedef struct packed {
        logic                valid;
        logic [data_w-1:0]   out;
        logic [regnum_w-1:0] dest;
        logic                write_enable;
        logic                overflow;
        logic                zero;
    } ex_regs_t;

    typedef struct packed {
        logic                valid;
        logic [data_w-1:0]   result;
        logic [regnum_w-1:0] dest;
        logic                write_enable;      // already qualified by valid and dest.
        logic                overflow;
    } wb_regs_t;

endpackage

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import core_pkg::*; (
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    input  alu_op_t           alu_op,
    output logic [data_w-1:0] out,
    output logic              overflow,
    output logic              zero,
    output logic              negative,
    output logic              borrow_out
);
    logic [data_w-1:0] sum;
    logic [data_w:0]   diff;    // extra bit carries the borrow.
    logic              add_ovf;
    logic              sub_ovf;

    assign sum  = a + b;
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb begin
        case (alu_op)
            ALU_ADD: out = sum;
            ALU_SUB: out = diff[data_w-1:0];
            ALU_AND: out = a & b;
            ALU_OR:  out = a | b;
            ALU_XOR: out = a ^ b;
            ALU_NOR: out = ~(a | b);
            default: out = sum;
        endcase
    end

    assign add_ovf = (a[data_w-1] == b[data_w-1]) && (sum[data_w-1] != a[data_w-1]);
    assign sub_ovf = (a[data_w-1] != b[data_w-1]) && (diff[data_w-1] != a[data_w-1]);

    assign overflow   = (alu_op == ALU_ADD) ? add_ovf : (alu_op == ALU_SUB) ? sub_ovf : 1'b0;
    assign negative   = (alu_op == ALU_SUB) ? diff[data_w-1] : sum[data_w-1];
    assign borrow_out = diff[data_w];
    assign zero       = (out == '0);

    // a difference or xor is zero exactly when the operands are equal.
    always_comb begin
        if (alu_op == ALU_SUB || alu_op == ALU_XOR)
            assert (zero == (a == b));
    end

endmodule

`default_nettype wire

// File: logic/barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter import core_pkg::*; (
    input  logic [data_w-1:0]  data,
    input  logic [shamt_w-1:0] shamt,
    input  logic               shift_right,
    input  logic               shift_arith,
    output logic [data_w-1:0]  out
);
    logic [data_w-1:0] res;

    // one stage per amount bit, stage i moves by 2**i.
    always_comb begin
        res = data;
        for (int i = 0; i < shamt_w; i++) begin
            if (shamt[i]) begin
                if (!shift_right)
                    res = res << (1 << i);
                else if (shift_arith)
                    res = $signed(res) >>> (1 << i);
                else
                    res = res >> (1 << i);
            end
        end
        out = res;
    end

endmodule

`default_nettype wire

// File: logic/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_unit import core_pkg::*; (
    input  id_regs_t      id_regs,
    input  ex_regs_t      ex_regs,
    input  wb_regs_t      wb,
    output forward_type_t forward_a,
    output forward_type_t forward_b
);
    logic ex_hit;
    logic wb_hit;

    // a nonzero dest is required, so r0 reads always come from the file.
    assign ex_hit = ex_regs.valid & ex_regs.write_enable & (ex_regs.dest != '0);
    assign wb_hit = wb.valid & wb.write_enable & (wb.dest != '0);

    // ex holds the newer value and wins over wb.
    assign forward_a = (ex_hit && ex_regs.dest == id_regs.src_a) ? FWD_EX :
                       (wb_hit && wb.dest == id_regs.src_a)      ? FWD_WB : FWD_REG;

    assign forward_b = (ex_hit && ex_regs.dest == id_regs.src_b) ? FWD_EX :
                       (wb_hit && wb.dest == id_regs.src_b)      ? FWD_WB : FWD_REG;

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic [regnum_w-1:0] rd_addr_a,
    input  logic [regnum_w-1:0] rd_addr_b,
    output logic [data_w-1:0]   rd_a,
    output logic [data_w-1:0]   rd_b,
    input  logic                wr_en,
    input  logic [regnum_w-1:0] wr_addr,
    input  logic [data_w-1:0]   wr_data
);
    logic [data_w-1:0] regs [32];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;   // caller never enables a write to r0.
        end
    end

    // read-during-write returns the value being written.
    assign rd_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

    r0_zero: assert property (@(posedge clock) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

// File: logic/core_id.sv
`timescale 1ns/1ps
`default_nettype none

module core_id import core_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  issue_op_t           issue,
    output logic [regnum_w-1:0] rd_addr_a,
    output logic [regnum_w-1:0] rd_addr_b,
    input  logic [data_w-1:0]   rd_a,
    input  logic [data_w-1:0]   rd_b,
    output id_regs_t            id_regs
);
    // operands are read in the issue cycle.
    assign rd_addr_a = issue.src_a;
    assign rd_addr_b = issue.src_b;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            id_regs <= '0;
        end else if (flush) begin
            id_regs <= '0;  // drop the op on the issue port.
        end else begin
            id_regs <= {issue, rd_a, rd_b};
        end
    end

endmodule

`default_nettype wire

// File: logic/core_ex.sv
`timescale 1ns/1ps
`default_nettype none

module core_ex import core_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              flush,
    input  id_regs_t          id_regs,
    input  logic [data_w-1:0] wb_result,
    input  forward_type_t     forward_a,
    input  forward_type_t     forward_b,
    output ex_regs_t          ex_regs
);
    logic [data_w-1:0] a_fwd;
    logic [data_w-1:0] b_fwd;
    logic [data_w-1:0] b_in;
    logic [data_w-1:0] sext_imm;
    logic [data_w-1:0] zext_imm;
    logic [data_w-1:0] alu_raw;
    logic [data_w-1:0] slt_out;
    logic [data_w-1:0] alu_out;
    logic [data_w-1:0] shift_raw;
    logic [data_w-1:0] shift_cut;
    logic [data_w-1:0] shift_out;
    logic [data_w-1:0] result;
    logic              overflow;
    logic              zero;
    logic              negative;
    logic              borrow_out;
    logic              shift_fill;
    logic              signed_lt;

    assign sext_imm = {{(data_w-imm_w){id_regs.imm[imm_w-1]}}, id_regs.imm};
    assign zext_imm = {{(data_w-imm_w){1'b0}}, id_regs.imm};

    // ######################################################################
    // operand selection
    // ######################################################################

    assign a_fwd = (forward_a == FWD_EX) ? ex_regs.out :
                   (forward_a == FWD_WB) ? wb_result : id_regs.a_data;
    assign b_fwd = (forward_b == FWD_EX) ? ex_regs.out :
                   (forward_b == FWD_WB) ? wb_result : id_regs.b_data;

    assign b_in = (id_regs.alu_src2 == SRC2_SEXT_IMM) ? sext_imm :
                  (id_regs.alu_src2 == SRC2_ZEXT_IMM) ? zext_imm : b_fwd;

    // ######################################################################
    // alu path
    // ######################################################################

    alu alu0 (
        .a          (a_fwd),
        .b          (b_in),
        .alu_op     (id_regs.alu_op),
        .out        (alu_raw),
        .overflow   (overflow),
        .zero       (zero),
        .negative   (negative),
        .borrow_out (borrow_out)
    );

    // signs differ means a is the smaller one exactly when it is negative.
    assign signed_lt = (a_fwd[data_w-1] ^ b_in[data_w-1]) ? a_fwd[data_w-1] : negative;

    assign slt_out = (id_regs.slt_type == SLT_SIGNED)   ? {{(data_w-1){1'b0}}, signed_lt} :
                     (id_regs.slt_type == SLT_UNSIGNED) ? {{(data_w-1){1'b0}}, borrow_out} :
                     alu_raw;

    assign alu_out = (id_regs.cut_alu_out32 == CUT_SEXT) ? {{32{slt_out[31]}}, slt_out[31:0]} :
                     (id_regs.cut_alu_out32 == CUT_ZEXT) ? {32'b0, slt_out[31:0]} : slt_out;

    // ######################################################################
    // shifter path
    // ######################################################################

    barrel_shifter shifter0 (
        .data        (b_fwd),
        .shamt       (id_regs.shamt),
        .shift_right (id_regs.shift_right),
        .shift_arith (id_regs.shift_arith),
        .out         (shift_raw)
    );

    assign shift_cut = (id_regs.cut_shifter_out32 == CUT_SEXT) ?
                       {{32{shift_raw[31]}}, shift_raw[31:0]} :
                       (id_regs.cut_shifter_out32 == CUT_ZEXT) ?
                       {32'b0, shift_raw[31:0]} : shift_raw;

    assign shift_fill = id_regs.shift_arith & shift_cut[data_w-1];

    assign shift_out = (id_regs.shifter_plus32 == PLUS32_LEFT)  ? {shift_cut[31:0], 32'b0} :
                       (id_regs.shifter_plus32 == PLUS32_RIGHT) ?
                       {{32{shift_fill}}, shift_cut[63:32]} : shift_cut;

    assign result = id_regs.lui             ? {sext_imm[47:0], 16'b0} :
                    id_regs.alu_shifter_src ? shift_out : alu_out;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ex_regs <= '0;
        end else if (flush) begin
            ex_regs <= '0;
        end else begin
            ex_regs.valid        <= id_regs.valid;
            ex_regs.out          <= result;
            ex_regs.dest         <= id_regs.dest;
            ex_regs.write_enable <= id_regs.write_enable;
            ex_regs.overflow     <= overflow & ~id_regs.ignore_overflow;
            ex_regs.zero         <= zero;
        end
    end

    // a flushed op never feeds the next one through the ex register.
    flush_kills_ex: assert property (@(posedge clock) disable iff (reset)
        flush |=> (forward_a != FWD_EX && forward_b != FWD_EX));

endmodule

`default_nettype wire

// File: logic/core_wb.sv
`timescale 1ns/1ps
`default_nettype none

module core_wb import core_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  ex_regs_t ex_regs,
    output wb_regs_t wb
);
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.valid        <= ex_regs.valid;
            wb.result       <= ex_regs.out;
            wb.dest         <= ex_regs.dest;
            // strobe only for live ops that target a real register.
            wb.write_enable <= ex_regs.valid & ex_regs.write_enable & (ex_regs.dest != '0);
            wb.overflow     <= ex_regs.overflow;
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_pipe_top import core_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      flush,
    input  issue_op_t issue,
    output wb_regs_t  wb
);
    id_regs_t            id_regs;
    ex_regs_t            ex_regs;
    forward_type_t       forward_a;
    forward_type_t       forward_b;
    logic [regnum_w-1:0] rd_addr_a;
    logic [regnum_w-1:0] rd_addr_b;
    logic [data_w-1:0]   rd_a;
    logic [data_w-1:0]   rd_b;
    logic                wr_en;

    assign wr_en = wb.valid & wb.write_enable;

    core_id id0 (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .issue     (issue),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .id_regs   (id_regs)
    );

    reg_file rf0 (
        .clock     (clock),
        .reset     (reset),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .wr_en     (wr_en),
        .wr_addr   (wb.dest),
        .wr_data   (wb.result)
    );

    forward_unit fwd0 (
        .id_regs   (id_regs),
        .ex_regs   (ex_regs),
        .wb        (wb),
        .forward_a (forward_a),
        .forward_b (forward_b)
    );

    core_ex ex0 (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .id_regs   (id_regs),
        .wb_result (wb.result),
        .forward_a (forward_a),
        .forward_b (forward_b),
        .ex_regs   (ex_regs)
    );

    core_wb wb0 (
        .clock   (clock),
        .reset   (reset),
        .ex_regs (ex_regs),
        .wb      (wb)
    );

endmodule

`default_nettype wire

// File: include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ######################################################################
// sequential model of the pipe, one call per issued op
// ######################################################################

logic [data_w-1:0] ref_regs [32];

function automatic void ref_clear();
    foreach (ref_regs[i])
        ref_regs[i] = '0;
endfunction

function automatic wb_regs_t ref_exec(input issue_op_t op, input logic [63:0] a,
                                      input logic [63:0] b);
    wb_regs_t    exp;
    logic [63:0] sext;
    logic [63:0] b_in;
    logic [63:0] sum;
    logic [64:0] diff;
    logic [63:0] r;
    logic [63:0] sh;
    logic        neg;
    logic        ovf;
    sext = {{48{op.imm[15]}}, op.imm};
    b_in = (op.alu_src2 == SRC2_SEXT_IMM) ? sext :
           (op.alu_src2 == SRC2_ZEXT_IMM) ? {48'b0, op.imm} : b;
    sum  = a + b_in;
    diff = {1'b0, a} - {1'b0, b_in};
    case (op.alu_op)
        ALU_SUB: r = diff[63:0];
        ALU_AND: r = a & b_in;
        ALU_OR:  r = a | b_in;
        ALU_XOR: r = a ^ b_in;
        ALU_NOR: r = ~(a | b_in);
        default: r = sum;
    endcase
    neg = (op.alu_op == ALU_SUB) ? diff[63] : sum[63];
    ovf = (op.alu_op == ALU_ADD) ? (a[63] == b_in[63]) && (sum[63] != a[63]) :
          (op.alu_op == ALU_SUB) ? (a[63] != b_in[63]) && (diff[63] != a[63]) : 1'b0;
    if (op.slt_type == SLT_SIGNED)
        r = {63'b0, (a[63] != b_in[63]) ? a[63] : neg};
    else if (op.slt_type == SLT_UNSIGNED)
        r = {63'b0, diff[64]};
    if (op.cut_alu_out32 == CUT_SEXT)
        r = {{32{r[31]}}, r[31:0]};
    else if (op.cut_alu_out32 == CUT_ZEXT)
        r = {32'b0, r[31:0]};
    if (!op.shift_right)
        sh = b << op.shamt;
    else if (op.shift_arith)
        sh = $signed(b) >>> op.shamt;
    else
        sh = b >> op.shamt;
    if (op.cut_shifter_out32 == CUT_SEXT)
        sh = {{32{sh[31]}}, sh[31:0]};
    else if (op.cut_shifter_out32 == CUT_ZEXT)
        sh = {32'b0, sh[31:0]};
    if (op.shifter_plus32 == PLUS32_LEFT)
        sh = {sh[31:0], 32'b0};
    else if (op.shifter_plus32 == PLUS32_RIGHT)
        sh = {{32{op.shift_arith & sh[63]}}, sh[63:32]};
    exp.valid        = op.valid;
    exp.result       = op.lui ? {sext[47:0], 16'b0} : op.alu_shifter_src ? sh : r;
    exp.dest         = op.dest;
    exp.write_enable = op.valid & op.write_enable & (op.dest != '0);
    exp.overflow     = ovf & ~op.ignore_overflow;
    return exp;
endfunction

// reads and updates the model registers in program order.
function automatic wb_regs_t ref_issue(input issue_op_t op);
    wb_regs_t exp;
    exp = ref_exec(op, ref_regs[op.src_a], ref_regs[op.src_b]);
    if (exp.write_enable)
        ref_regs[op.dest] = exp.result;
    return exp;
endfunction

`endif

// File: tests/tb_exec_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_pipe
    import core_pkg::*;
();
    localparam int n_ops        = 400;
    localparam int reset_cycles = 16;
    localparam int cycle_limit  = 3 * n_ops + reset_cycles + 20;

    logic        clock;
    logic        reset;
    logic        flush;
    issue_op_t   issue;
    wb_regs_t    wb;
    logic [31:0] lfsr_state;
    int          cycle = 0;
    int          errors = 0;
    issue_op_t   ops [n_ops];
    logic        flush_at [n_ops];
    wb_regs_t    exp_q [$];
    int          due_q [$];      // cycle in which each expected result shows on wb.

    `include "tb_ref_model.svh"

    exec_pipe_top dut0 (
        .clock (clock),
        .reset (reset),
        .flush (flush),
        .issue (issue),
        .wb    (wb)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ######################################################################
    // stimulus helpers
    // ######################################################################

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic issue_op_t random_op();
        issue_op_t op;
        op = '0;
        op.valid             = (lfsr_bits(4) != 0);
        op.src_a             = 5'(lfsr_bits(3));    // r0..r7 keeps dependencies dense.
        op.src_b             = 5'(lfsr_bits(3));
        op.dest              = 5'(lfsr_bits(3));
        op.imm               = 16'(lfsr_bits(16));
        op.shamt             = 5'(lfsr_bits(5));
        op.alu_op            = alu_op_t'(3'(lfsr_bits(8) % 6));
        op.alu_src2          = alu_src2_t'(2'(lfsr_bits(8) % 3));
        op.slt_type          = (lfsr_bits(2) == 0) ? slt_type_t'(2'(1 + lfsr_bits(1))) : SLT_NONE;
        op.cut_alu_out32     = cut32_t'(2'(lfsr_bits(8) % 3));
        op.alu_shifter_src   = (lfsr_bits(2) == 0);
        op.shift_right       = 1'(lfsr_bits(1));
        op.shift_arith       = 1'(lfsr_bits(1));
        op.cut_shifter_out32 = cut32_t'(2'(lfsr_bits(8) % 3));
        op.shifter_plus32    = plus32_t'(2'(lfsr_bits(8) % 3));
        op.lui               = (lfsr_bits(3) == 0);
        op.write_enable      = (lfsr_bits(3) != 0);
        op.ignore_overflow   = 1'(lfsr_bits(1));
        return op;
    endfunction

    // ######################################################################
    // checking
    // ######################################################################

    task automatic stop_run();
        errors++;
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycle);
            stop_run();
        end
    endtask

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d results still expected",
                     cycle, exp_q.size());
            stop_run();
        end
    end

    always @(negedge clock) begin
        wb_regs_t head;
        if (!reset) begin
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                head = exp_q.pop_front();
                void'(due_q.pop_front());
                check_value("wb.valid", 64'(wb.valid), 64'(head.valid));
                check_value("wb.result", wb.result, head.result);
                check_value("wb.dest", 64'(wb.dest), 64'(head.dest));
                check_value("wb.write_enable", 64'(wb.write_enable), 64'(head.write_enable));
                check_value("wb.overflow", 64'(wb.overflow), 64'(head.overflow));
            end else begin
                check_value("wb.valid", 64'(wb.valid), 64'(1'b0));
            end
        end
    end

    initial begin
        wb_regs_t exp;
        logic     dropped;
        reset = 1'b1;
        flush = 1'b0;
        issue = '0;
        lfsr_state = 32'hfe87;
        ref_clear();
        for (int i = 0; i < n_ops; i++) begin
            ops[i]      = random_op();
            flush_at[i] = (lfsr_bits(5) == 0);
        end
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < n_ops; i++) begin
            @(posedge clock);
            issue <= ops[i];
            flush <= flush_at[i];
            // a flush kills the op beside it and the one issued just before.
            dropped = flush_at[i] || (i + 1 < n_ops && flush_at[i + 1]);
            if (!dropped) begin
                exp = ref_issue(ops[i]);
                if (exp.valid) begin
                    exp_q.push_back(exp);
                    due_q.push_back(cycle + 4);   // cycle has not counted this edge yet.
                end
            end
        end
        @(posedge clock);
        issue <= '0;
        flush <= 1'b0;
        while (exp_q.size() != 0)
            @(negedge clock);
        repeat (4) @(negedge clock);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
logic/core_pkg.sv
logic/alu.sv
logic/barrel_shifter.sv
logic/forward_unit.sv
logic/reg_file.sv
logic/core_id.sv
logic/core_ex.sv
logic/core_wb.sv
logic/exec_pipe_top.sv
tests/tb_exec_pipe.sv

// File: Makefile
# Verilator build and run of the execute pipeline testbench.

VERILATOR ?= verilator
TOP       ?= tb_exec_pipe
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
